//--- verilog/chipBusPkg.sv
// ========================================
// Chip-bus bridge shared definitions
// Widths, SIZ codes, arbiter states and the
// access and lane-enable structs
// ========================================

package chipBusPkg;

    typedef logic [1:0]  addrLow;   // A1, A0 of the CPU access
    typedef logic [1:0]  xferSize;  // 68030 SIZ code
    typedef logic [3:0]  laneMask;  // UU, UM, LM, LL, active low
    typedef logic [31:0] cpuWord;
    typedef logic [15:0] chipWord;

    // SIZ encodings
    localparam xferSize sizeLong  = 2'b00;
    localparam xferSize sizeByte  = 2'b01;
    localparam xferSize sizeWord  = 2'b10;
    localparam xferSize sizeThree = 2'b11;  // Decoded like a long word

    // Owner of the current chip-bus cycle
    typedef enum logic [1:0] {
        busIdle,
        busDma,
        busCpu
    } busState;

    // Captured CPU access, 37 bits
    typedef struct packed {
        addrLow  addr;
        xferSize size;
        logic    readNotWrite;
        cpuWord  writeData;
    } cpuAccess;

    // Decoder outputs, 10 bits
    typedef struct packed {
        laneMask cpuLanesN;   // 32-bit CPU side
        laneMask chipLanesN;  // Chip RAM side
        logic    uds;         // 68000 upper data strobe
        logic    lds;         // 68000 lower data strobe
    } laneEnables;

endpackage

//--- verilog/byteLaneDecoder.sv
// ========================================
// Byte-lane decoder
// CPU and chip RAM byte enables, UDS and LDS
// ========================================

module byteLaneDecoder (
    input  chipBusPkg::cpuAccess   access,
    input  logic                   cpuCycle,
    input  logic                   dmaCycle,
    input  logic                   casUpperN,
    input  logic                   casLowerN,
    input  logic                   dbEnN,
    output chipBusPkg::laneEnables lanes
);

    chipBusPkg::laneMask cpuSel;   // Lanes picked by address and size, active high
    chipBusPkg::laneMask dmaSel;   // Lanes picked by chipset CAS strobes
    chipBusPkg::laneMask chipSel;  // Lanes driven toward chip RAM
    logic isLong;
    logic isByte;
    logic cpuWrite;

    assign isLong   = (access.size == chipBusPkg::sizeLong) ||
                      (access.size == chipBusPkg::sizeThree);
    assign isByte   = (access.size == chipBusPkg::sizeByte);
    assign cpuWrite = !access.readNotWrite;

    // Address and size decode for the 32-bit side
    always_comb begin
        case (access.size)
            chipBusPkg::sizeByte: cpuSel = 4'b1000 >> access.addr;  // One lane by A1:A0
            chipBusPkg::sizeWord: cpuSel = access.addr[1] ? 4'b0011 : 4'b1100;
            default:              cpuSel = 4'b1111;                  // Long or three-byte
        endcase
    end

    // DMA slots
    // dbEnN high routes the chipset word to the upper half, low to the lower half
    always_comb begin
        dmaSel[3] = !casUpperN && dbEnN;   // UU
        dmaSel[2] = !casLowerN && dbEnN;   // UM
        dmaSel[1] = !casUpperN && !dbEnN;  // LM
        dmaSel[0] = !casLowerN && !dbEnN;  // LL
    end

    // Chip side follows whichever owner holds the bus
    always_comb begin
        if (cpuCycle)
            chipSel = cpuSel;
        else if (dmaCycle)
            chipSel = dmaSel;
        else
            chipSel = '0;  // Idle bus, nothing enabled
    end

    assign lanes.cpuLanesN  = ~cpuSel;
    assign lanes.chipLanesN = ~chipSel;

    // Strobes only drop on CPU writes at an even address
    assign lanes.uds = !(cpuWrite && !access.addr[0] && !isLong);
    assign lanes.lds = !(cpuWrite && !access.addr[0] && isByte);

    // Both owners come from one arbiter state, never overlapping
    always_comb begin
        assert (!(cpuCycle && dmaCycle))
            else $error("CPU and DMA cycles active together");
    end

endmodule

//--- verilog/cycleArbiter.sv
// ========================================
// Chip-bus cycle arbiter
// Grants chip RAM to DMA or CPU, holds the
// CPU access and times the acknowledge
// ========================================

module cycleArbiter #(
    parameter int cpuCycleLength = 4  // Clocks per CPU cycle, 2 to 8
) (
    input  logic                  clk40,
    input  logic                  reset,
    input  logic                  cpuStart,
    input  chipBusPkg::addrLow    cpuAddr,
    input  chipBusPkg::xferSize   cpuSize,
    input  logic                  cpuRnW,
    input  chipBusPkg::cpuWord    cpuWriteData,
    input  logic                  dmaRequest,
    output chipBusPkg::cpuAccess  access,
    output logic                  cpuCycle,
    output logic                  dmaCycle,
    output logic                  cpuAck
);

    localparam int countWidth = $clog2(cpuCycleLength);
    // Count value on the clock before the last CPU clock
    localparam logic [countWidth-1:0] lastCount = countWidth'(cpuCycleLength - 2);

    chipBusPkg::busState   state;
    logic                  pending;     // CPU access waiting or in progress
    logic [countWidth-1:0] cycleCount;  // Clocks spent in busCpu

    // Cycle levels come straight from the state register
    assign cpuCycle = (state == chipBusPkg::busCpu);
    assign dmaCycle = (state == chipBusPkg::busDma);

    // Access register, loaded on every start pulse
    always_ff @(posedge clk40) begin
        if (cpuStart) begin
            access.addr         <= cpuAddr;
            access.size         <= cpuSize;
            access.readNotWrite <= cpuRnW;
            access.writeData    <= cpuWriteData;
        end
    end

    always_ff @(posedge clk40) begin
        if (reset) begin
            state      <= chipBusPkg::busIdle;
            pending    <= 1'b0;
            cpuAck     <= 1'b0;
            cycleCount <= '0;
        end else begin
            case (state)
                chipBusPkg::busIdle: begin
                    if (dmaRequest) begin
                        state <= chipBusPkg::busDma;  // DMA wins a tie
                    end else if (pending) begin
                        state      <= chipBusPkg::busCpu;
                        cycleCount <= '0;
                    end
                end

                chipBusPkg::busDma: begin
                    if (!dmaRequest)
                        state <= chipBusPkg::busIdle;  // Slot over
                end

                chipBusPkg::busCpu: begin
                    cycleCount <= cycleCount + 1'b1;
                    cpuAck     <= (cycleCount == lastCount);  // Flag the final clock
                    if (cpuAck) begin
                        // Last clock done, release the bus
                        state   <= chipBusPkg::busIdle;
                        cpuAck  <= 1'b0;
                        pending <= 1'b0;
                    end
                end

                default: state <= chipBusPkg::busIdle;
            endcase

            // New request, picked up on the next idle clock
            if (cpuStart)
                pending <= 1'b1;
        end
    end

    // Acknowledge is a single pulse inside a CPU cycle
    ackInCycle: assert property (
        @(posedge clk40) disable iff (reset)
        cpuAck |-> cpuCycle
    ) else $error("cpuAck outside a CPU cycle");

    ackOnePulse: assert property (
        @(posedge clk40) disable iff (reset)
        cpuAck |=> !cpuAck
    ) else $error("cpuAck longer than one clock");

    // CPU side waits for the acknowledge before the next access
    noStartWhilePending: assert property (
        @(posedge clk40) disable iff (reset)
        cpuStart |-> !pending
    ) else $error("cpuStart while an access is pending");

endmodule

//--- verilog/dataLaneSteer.sv
// ========================================
// Chip-bus data steering
// CPU write half onto the 16-bit chip bus,
// read word duplicated back to the CPU
// ========================================

module dataLaneSteer (
    input  logic                 clk40,
    input  logic                 reset,
    input  chipBusPkg::cpuAccess access,
    input  logic                 cpuCycle,
    input  logic                 cpuAck,
    input  chipBusPkg::chipWord  chipReadData,
    output chipBusPkg::chipWord  chipWriteData,
    output chipBusPkg::cpuWord   cpuReadData
);

    logic cpuCycleDly;   // cpuCycle one clock late
    logic cpuCycleRise;  // First clock of a CPU cycle
    chipBusPkg::chipWord writeHalf;

    assign cpuCycleRise = cpuCycle && !cpuCycleDly;

    // A1 picks the half of the long word that sits on the 16-bit port
    assign writeHalf = access.addr[1] ? access.writeData[15:0]
                                      : access.writeData[31:16];

    always_ff @(posedge clk40) begin
        if (reset)
            cpuCycleDly <= 1'b0;
        else
            cpuCycleDly <= cpuCycle;
    end

    // Write word
    // Loaded at the rising edge, held for the rest of the cycle and after
    always_ff @(posedge clk40) begin
        if (reset) begin
            chipWriteData <= '0;
        end else if (cpuCycleRise) begin
            chipWriteData <= writeHalf;
        end
    end

    // Read word
    // A 16-bit port answers on both halves so dynamic sizing finds it either way
    always_ff @(posedge clk40) begin
        if (reset) begin
            cpuReadData <= '0;
        end else if (cpuAck) begin
            cpuReadData <= {chipReadData, chipReadData};  // Valid the clock after ack
        end
    end

    // Data sampled at ack belongs to a live CPU cycle
    ackHasData: assert property (
        @(posedge clk40) disable iff (reset)
        cpuAck |-> cpuCycleDly
    ) else $error("cpuAck on the first clock of a CPU cycle");

endmodule

//--- verilog/chipBusBridge.sv
// ========================================
// 68030 to chipset chip-bus bridge
// Arbiter, byte-lane decoder and data path
// ========================================

module chipBusBridge #(
    parameter int cpuCycleLength = 4  // Clocks per CPU cycle
) (
    input  logic                   clk40,
    input  logic                   reset,
    input  logic                   cpuStart,
    input  chipBusPkg::addrLow     cpuAddr,
    input  chipBusPkg::xferSize    cpuSize,
    input  logic                   cpuRnW,
    input  chipBusPkg::cpuWord     cpuWriteData,
    input  logic                   dmaRequest,
    input  logic                   casUpperN,
    input  logic                   casLowerN,
    input  logic                   dbEnN,
    input  chipBusPkg::chipWord    chipReadData,
    output logic                   cpuAck,
    output chipBusPkg::cpuWord     cpuReadData,
    output chipBusPkg::chipWord    chipWriteData,
    output chipBusPkg::laneEnables lanes,
    output logic                   cpuCycle,
    output logic                   dmaCycle
);

    chipBusPkg::cpuAccess access;  // Access held for the current CPU cycle

    cycleArbiter #(
        .cpuCycleLength(cpuCycleLength)
    ) arbiter (
        .clk40       (clk40),
        .reset       (reset),
        .cpuStart    (cpuStart),
        .cpuAddr     (cpuAddr),
        .cpuSize     (cpuSize),
        .cpuRnW      (cpuRnW),
        .cpuWriteData(cpuWriteData),
        .dmaRequest  (dmaRequest),
        .access      (access),
        .cpuCycle    (cpuCycle),
        .dmaCycle    (dmaCycle),
        .cpuAck      (cpuAck)
    );

    byteLaneDecoder decoder (
        .access   (access),
        .cpuCycle (cpuCycle),
        .dmaCycle (dmaCycle),
        .casUpperN(casUpperN),
        .casLowerN(casLowerN),
        .dbEnN    (dbEnN),
        .lanes    (lanes)
    );

    dataLaneSteer steer (
        .clk40        (clk40),
        .reset        (reset),
        .access       (access),
        .cpuCycle     (cpuCycle),
        .cpuAck       (cpuAck),
        .chipReadData (chipReadData),
        .chipWriteData(chipWriteData),
        .cpuReadData  (cpuReadData)
    );

endmodule

//--- dv/chipBusTb.sv
// ========================================
// Chip-bus bridge testbench
// Reads cases from a file, runs CPU and DMA
// cycles and checks lanes, strobes and data
// ========================================

module chipBusTb;

    localparam int cpuCycleLength = 4;
    localparam int clocksPerCase  = 40;  // Watchdog budget per case
    localparam int handshakeLimit = 20;  // Longest wait for one level change

    typedef enum logic [1:0] {
        kindCpu,
        kindDma,
        kindBoth
    } caseKind;

    // One line of the case file
    typedef struct packed {
        caseKind                kind;
        chipBusPkg::cpuAccess   access;
        logic                   casUpperN;
        logic                   casLowerN;
        logic                   dbEnN;
        chipBusPkg::chipWord    readData;
        chipBusPkg::laneEnables expLanes;  // Lanes and strobes during the cycle
        chipBusPkg::chipWord    expWrite;
        chipBusPkg::cpuWord     expRead;
    } testCase;

    logic                   clk40;
    logic                   reset;
    logic                   cpuStart;
    chipBusPkg::addrLow     cpuAddr;
    chipBusPkg::xferSize    cpuSize;
    logic                   cpuRnW;
    chipBusPkg::cpuWord     cpuWriteData;
    logic                   dmaRequest;
    logic                   casUpperN;
    logic                   casLowerN;
    logic                   dbEnN;
    chipBusPkg::chipWord    chipReadData;
    logic                   cpuAck;
    chipBusPkg::cpuWord     cpuReadData;
    chipBusPkg::chipWord    chipWriteData;
    chipBusPkg::laneEnables lanes;
    logic                   cpuCycle;
    logic                   dmaCycle;

    testCase cases[$];
    logic    casesReady;

    chipBusBridge #(
        .cpuCycleLength(cpuCycleLength)
    ) dut (
        .clk40        (clk40),
        .reset        (reset),
        .cpuStart     (cpuStart),
        .cpuAddr      (cpuAddr),
        .cpuSize      (cpuSize),
        .cpuRnW       (cpuRnW),
        .cpuWriteData (cpuWriteData),
        .dmaRequest   (dmaRequest),
        .casUpperN    (casUpperN),
        .casLowerN    (casLowerN),
        .dbEnN        (dbEnN),
        .chipReadData (chipReadData),
        .cpuAck       (cpuAck),
        .cpuReadData  (cpuReadData),
        .chipWriteData(chipWriteData),
        .lanes        (lanes),
        .cpuCycle     (cpuCycle),
        .dmaCycle     (dmaCycle)
    );

    initial clk40 = 1'b0;
    always #5 clk40 = ~clk40;  // Period 10

    task automatic haltOnFailure();
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic reportProblem(input string reason);
        $display("%s", reason);
        haltOnFailure();
    endtask

    task automatic checkLanes(input string name, input chipBusPkg::laneMask expected,
                              input chipBusPkg::laneMask actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            haltOnFailure();
        end
    endtask

    task automatic checkStrobe(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
            haltOnFailure();
        end
    endtask

    task automatic checkChipWord(input string name, input chipBusPkg::chipWord expected,
                                 input chipBusPkg::chipWord actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            haltOnFailure();
        end
    endtask

    task automatic checkCpuWord(input string name, input chipBusPkg::cpuWord expected,
                                input chipBusPkg::cpuWord actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            haltOnFailure();
        end
    endtask

    // Clock counts between handshake events
    task automatic checkCount(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
            haltOnFailure();
        end
    endtask

    function automatic string caseName(input int idx, input testCase tc);
        string dirText;
        dirText = tc.access.readNotWrite ? "read" : "write";
        if (tc.kind == kindDma)
            return $sformatf("case %0d dma cas=%b%b dbEn=%b", idx, tc.casUpperN,
                             tc.casLowerN, tc.dbEnN);
        return $sformatf("case %0d %s A=%0d SIZ=%0d %s", idx,
                         (tc.kind == kindBoth) ? "both" : "cpu",
                         tc.access.addr, tc.access.size, dirText);
    endfunction

    // Parse the case file, skipping comments and blank lines
    task automatic loadCases();
        int               fd;
        int               fields;
        int               lineNo;
        logic             done;
        logic [8*256-1:0] lineBuf;
        logic [31:0]      kindTok;
        logic [31:0]      col [0:13];
        testCase          tc;
        fd = $fopen("dv/chipBusCases.txt", "r");
        if (fd == 0)
            reportProblem("Cannot open the case file dv/chipBusCases.txt");
        lineNo = 0;
        done   = 1'b0;
        while (!done) begin
            lineBuf = '0;
            if ($fgets(lineBuf, fd) == 0) begin
                done = 1'b1;
            end else begin
                lineNo++;
                kindTok = '0;
                fields = $sscanf(lineBuf, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                 kindTok, col[0], col[1], col[2], col[3], col[4], col[5],
                                 col[6], col[7], col[8], col[9], col[10], col[11],
                                 col[12], col[13]);
                if (fields > 0 && kindTok != 32'("#")) begin
                    if (fields != 15)
                        reportProblem($sformatf("Case file line %0d is malformed", lineNo));
                    if (kindTok == 32'("cpu"))
                        tc.kind = kindCpu;
                    else if (kindTok == 32'("dma"))
                        tc.kind = kindDma;
                    else if (kindTok == 32'("both"))
                        tc.kind = kindBoth;
                    else
                        reportProblem($sformatf("Case file line %0d has an unknown kind",
                                                lineNo));
                    tc.access.addr          = col[0][1:0];
                    tc.access.size          = col[1][1:0];
                    tc.access.readNotWrite  = col[2][0];
                    tc.access.writeData     = col[3];
                    tc.casUpperN            = col[4][0];
                    tc.casLowerN            = col[5][0];
                    tc.dbEnN                = col[6][0];
                    tc.readData             = col[7][15:0];
                    tc.expLanes.cpuLanesN   = col[8][3:0];
                    tc.expLanes.chipLanesN  = col[9][3:0];
                    tc.expLanes.uds         = col[10][0];
                    tc.expLanes.lds         = col[11][0];
                    tc.expWrite             = col[12][15:0];
                    tc.expRead              = col[13];
                    cases.push_back(tc);
                end
            end
        end
        $fclose(fd);
        if (cases.size() == 0)
            reportProblem("The case file holds no test cases");
    endtask

    // One-clock start pulse with the access fields
    task automatic driveCpuStart(input testCase tc);
        @(posedge clk40);
        cpuStart     <= 1'b1;
        cpuAddr      <= tc.access.addr;
        cpuSize      <= tc.access.size;
        cpuRnW       <= tc.access.readNotWrite;
        cpuWriteData <= tc.access.writeData;
        chipReadData <= tc.readData;
        @(posedge clk40);
        cpuStart     <= 1'b0;
    endtask

    // Follows a CPU cycle to its acknowledge and checks everything seen on the way
    task automatic waitForAck(input testCase tc, input string name, input int cycleSoFar,
                              input logic checkLatency);
        int clocks;
        int cycleClocks;
        clocks      = 0;
        cycleClocks = cycleSoFar;
        do begin
            @(negedge clk40);
            clocks++;
            if (cpuCycle)
                cycleClocks++;
            if (clocks > handshakeLimit)
                reportProblem($sformatf("%s: cpuAck never arrived", name));
        end while (!cpuAck);
        checkStrobe({name, " cpuCycle at ack"}, 1'b1, cpuCycle);
        if (checkLatency)
            checkCount({name, " start to ack clocks"}, cpuCycleLength + 1, clocks);
        checkCount({name, " cpuCycle clocks up to ack"}, cpuCycleLength, cycleClocks);
        checkLanes({name, " cpuLanesN"}, tc.expLanes.cpuLanesN, lanes.cpuLanesN);
        checkLanes({name, " chipLanesN"}, tc.expLanes.chipLanesN, lanes.chipLanesN);
        checkStrobe({name, " uds"}, tc.expLanes.uds, lanes.uds);
        checkStrobe({name, " lds"}, tc.expLanes.lds, lanes.lds);
        if (!tc.access.readNotWrite)
            checkChipWord({name, " chipWriteData"}, tc.expWrite, chipWriteData);
        @(negedge clk40);  // Ack was the last clock of the cycle
        checkStrobe({name, " cpuCycle after ack"}, 1'b0, cpuCycle);
        checkStrobe({name, " cpuAck after ack"}, 1'b0, cpuAck);
        checkCpuWord({name, " cpuReadData"}, tc.expRead, cpuReadData);
    endtask

    task automatic waitForDma(input string name, input logic level, output int clocks);
        clocks = 0;
        do begin
            @(negedge clk40);
            clocks++;
            if (clocks > handshakeLimit)
                reportProblem($sformatf("%s: dmaCycle stuck at %b", name, !level));
        end while (dmaCycle !== level);
    endtask

    task automatic runDmaSlot(input testCase tc, input string name);
        int clocks;
        @(posedge clk40);
        dmaRequest <= 1'b1;
        casUpperN  <= tc.casUpperN;
        casLowerN  <= tc.casLowerN;
        dbEnN      <= tc.dbEnN;
        waitForDma(name, 1'b1, clocks);
        checkCount({name, " dmaCycle rise clocks"}, 2, clocks);  // Clock after the request
        checkStrobe({name, " cpuCycle in DMA"}, 1'b0, cpuCycle);
        checkLanes({name, " chipLanesN"}, tc.expLanes.chipLanesN, lanes.chipLanesN);
        @(posedge clk40);
        dmaRequest <= 1'b0;
        casUpperN  <= 1'b1;
        casLowerN  <= 1'b1;
        dbEnN      <= 1'b1;
        waitForDma(name, 1'b0, clocks);
        checkCount({name, " dmaCycle fall clocks"}, 2, clocks);  // Falls a clock later
        checkLanes({name, " idle chipLanesN"}, 4'hf, lanes.chipLanesN);
    endtask

    // CPU start lands inside a DMA slot and has to wait it out
    task automatic runBothCase(input testCase tc, input string name);
        int clocks;
        @(posedge clk40);
        dmaRequest <= 1'b1;
        casUpperN  <= tc.casUpperN;
        casLowerN  <= tc.casLowerN;
        dbEnN      <= tc.dbEnN;
        waitForDma(name, 1'b1, clocks);
        driveCpuStart(tc);
        repeat (2) begin
            @(negedge clk40);
            checkStrobe({name, " cpuCycle held off"}, 1'b0, cpuCycle);
            checkStrobe({name, " dmaCycle kept"}, 1'b1, dmaCycle);
        end
        @(posedge clk40);
        dmaRequest <= 1'b0;
        casUpperN  <= 1'b1;
        casLowerN  <= 1'b1;
        dbEnN      <= 1'b1;
        waitForDma(name, 1'b0, clocks);
        checkStrobe({name, " cpuCycle as DMA ends"}, 1'b0, cpuCycle);
        @(negedge clk40);
        checkStrobe({name, " cpuCycle after DMA"}, 1'b1, cpuCycle);
        waitForAck(tc, name, 1, 1'b0);
    endtask

    // Watchdog sized from the number of cases
    initial begin
        int limit;
        wait (casesReady === 1'b1);
        limit = (cases.size() + 2) * clocksPerCase;
        repeat (limit) @(posedge clk40);
        reportProblem($sformatf("Watchdog: run hung, not finished after %0d clocks", limit));
    end

    initial begin
        int    gap;
        string name;
        void'($urandom(32'hfe78_5788));  // Seed the stream once
        casesReady   = 1'b0;
        reset        = 1'b1;
        cpuStart     = 1'b0;
        cpuAddr      = '0;
        cpuSize      = '0;
        cpuRnW       = 1'b1;
        cpuWriteData = '0;
        dmaRequest   = 1'b0;
        casUpperN    = 1'b1;  // Strobes idle high
        casLowerN    = 1'b1;
        dbEnN        = 1'b1;
        chipReadData = '0;
        loadCases();
        casesReady = 1'b1;
        repeat (4) @(posedge clk40);
        reset <= 1'b0;
        @(negedge clk40);
        checkStrobe("reset cpuCycle", 1'b0, cpuCycle);
        checkStrobe("reset dmaCycle", 1'b0, dmaCycle);
        checkStrobe("reset cpuAck", 1'b0, cpuAck);
        checkLanes("reset chipLanesN", 4'hf, lanes.chipLanesN);
        foreach (cases[i]) begin
            gap = $urandom % 4;  // Idle clocks between cases
            repeat (gap) @(posedge clk40);
            name = caseName(i, cases[i]);
            case (cases[i].kind)
                kindCpu: begin
                    driveCpuStart(cases[i]);
                    waitForAck(cases[i], name, 0, 1'b1);
                end
                kindDma:  runDmaSlot(cases[i], name);
                default:  runBothCase(cases[i], name);
            endcase
        end
        repeat (2) @(posedge clk40);
        $display("No errors");
        $finish;
    end

endmodule

//--- dv/chipBusCases.txt
# kind addr size rnw writeData casUpperN casLowerN dbEnN chipReadData (hex)
# then expected cpuLanesN chipLanesN uds lds chipWriteData cpuReadData, dma lines check chipLanesN only
cpu 0 1 1 00000000 1 1 1 a5c3 7 7 1 1 0000 a5c3a5c3
cpu 0 1 0 11223344 1 1 1 0f0f 7 7 0 0 1122 0f0f0f0f
cpu 1 1 1 00000000 1 1 1 1234 b b 1 1 0000 12341234
cpu 1 1 0 55667788 1 1 1 4321 b b 1 1 5566 43214321
cpu 2 1 1 00000000 1 1 1 beef d d 1 1 0000 beefbeef
cpu 2 1 0 99aabbcc 1 1 1 cafe d d 0 0 bbcc cafecafe
cpu 3 1 1 00000000 1 1 1 0001 e e 1 1 0000 00010001
cpu 3 1 0 deadbeef 1 1 1 8000 e e 1 1 beef 80008000
cpu 0 2 1 00000000 1 1 1 f00d 3 3 1 1 0000 f00df00d
cpu 0 2 0 0badc0de 1 1 1 7777 3 3 0 1 0bad 77777777
cpu 1 2 1 00000000 1 1 1 2468 3 3 1 1 0000 24682468
cpu 1 2 0 13579bdf 1 1 1 aaaa 3 3 1 1 1357 aaaaaaaa
cpu 2 2 1 00000000 1 1 1 5555 c c 1 1 0000 55555555
cpu 2 2 0 fedcba98 1 1 1 0101 c c 0 1 ba98 01010101
cpu 3 2 1 00000000 1 1 1 9abc c c 1 1 0000 9abc9abc
cpu 3 2 0 a1b2c3d4 1 1 1 3c3c c c 1 1 c3d4 3c3c3c3c
cpu 0 3 1 00000000 1 1 1 0ff0 0 0 1 1 0000 0ff00ff0
cpu 0 3 0 c001d00d 1 1 1 1111 0 0 1 1 c001 11111111
cpu 1 3 1 00000000 1 1 1 2222 0 0 1 1 0000 22222222
cpu 1 3 0 01234567 1 1 1 3333 0 0 1 1 0123 33333333
cpu 2 3 1 00000000 1 1 1 4444 0 0 1 1 0000 44444444
cpu 2 3 0 89abcdef 1 1 1 6666 0 0 1 1 cdef 66666666
cpu 3 3 1 00000000 1 1 1 8888 0 0 1 1 0000 88888888
cpu 3 3 0 76543210 1 1 1 9999 0 0 1 1 3210 99999999
cpu 0 0 1 00000000 1 1 1 abcd 0 0 1 1 0000 abcdabcd
cpu 0 0 0 a5a5f0f0 1 1 1 ffff 0 0 1 1 a5a5 ffffffff
cpu 1 0 1 00000000 1 1 1 7e57 0 0 1 1 0000 7e577e57
cpu 1 0 0 5a5a0f0f 1 1 1 0000 0 0 1 1 5a5a 00000000
cpu 2 0 1 00000000 1 1 1 d00d 0 0 1 1 0000 d00dd00d
cpu 2 0 0 3c3cc3c3 1 1 1 1357 0 0 1 1 c3c3 13571357
cpu 3 0 1 00000000 1 1 1 b00b 0 0 1 1 0000 b00bb00b
cpu 3 0 0 600df00d 1 1 1 2468 0 0 1 1 f00d 24682468
dma 0 0 1 00000000 0 0 0 0000 0 c 1 1 0000 00000000
dma 0 0 1 00000000 0 0 1 0000 0 3 1 1 0000 00000000
dma 0 0 1 00000000 0 1 0 0000 0 d 1 1 0000 00000000
dma 0 0 1 00000000 0 1 1 0000 0 7 1 1 0000 00000000
dma 0 0 1 00000000 1 0 0 0000 0 e 1 1 0000 00000000
dma 0 0 1 00000000 1 0 1 0000 0 b 1 1 0000 00000000
dma 0 0 1 00000000 1 1 0 0000 0 f 1 1 0000 00000000
dma 0 0 1 00000000 1 1 1 0000 0 f 1 1 0000 00000000
both 0 2 0 cafef00d 0 0 1 1234 3 3 0 1 cafe 12341234
both 3 1 1 00000000 1 0 0 5678 e e 1 1 0000 56785678

//--- sources.f
verilog/chipBusPkg.sv
verilog/byteLaneDecoder.sv
verilog/cycleArbiter.sv
verilog/dataLaneSteer.sv
verilog/chipBusBridge.sv
dv/chipBusTb.sv

//--- Makefile
# Verilator build and run of the chip-bus bridge testbench

VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := chipBusTb
FILELIST  := sources.f
OBJDIR    := obj_dir
PASSTEXT  := No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSTEXT)"

clean:
	rm -rf $(OBJDIR)
